// ==== logic/hps_pkg.sv ====
// Host link word types, command codes, magic word and status word layout

package hps_pkg;

	// ======================================================================
	// Word types
	// ======================================================================

	// One word in either direction between host and core
	typedef logic [31:0] host_word_t;

	// Command or data field in bits 15..0 of the host word
	typedef logic [15:0] io_data_t;

	// Command byte taken from the first word of a command
	typedef logic [7:0] cmd_t;

	// ======================================================================
	// Host to core word
	// ======================================================================

	localparam int HOST_CLK_BIT   = 17;
	localparam int HOST_UIO_BIT   = 20;
	// Low while the host is still bringing up the link
	localparam int HOST_READY_BIT = 31;

	localparam cmd_t CMD_TIMING = 8'h20;
	localparam cmd_t CMD_LED    = 8'h25;
	localparam cmd_t CMD_VOLUME = 8'h26;

	// Number of data words that CMD_TIMING loads
	localparam int TIMING_WORDS = 8;

	// ======================================================================
	// Core to host word
	// ======================================================================

	// Generic core signature, host refuses to talk to anything else
	localparam host_word_t CORE_MAGIC = 32'h5CA6_23A4;

	localparam logic [1:0] IO_VER = 2'd1;

	localparam int STAT_BTN_USER_BIT = 30;
	localparam int STAT_BTN_OSD_BIT  = 29;
	localparam int STAT_VER_LSB      = 16;
	localparam int STAT_ACK_BIT      = 15;

endpackage

// ==== logic/av_pkg.sv ====
// Audio sample, mix and volume types, video timing type and its defaults

package av_pkg;

	// ======================================================================
	// Audio
	// ======================================================================

	typedef logic [15:0] sample_t;

	// Cross-mix mode, 0 keeps channels apart, 3 is full mono
	typedef logic [1:0] mix_t;

	// Bit 4 mutes, bits 3..0 give the right shift
	typedef logic [4:0] vol_t;

	// ======================================================================
	// Video timing
	// ======================================================================

	typedef logic [11:0] timing_t;

	// 1280x720 at 60 Hz
	localparam timing_t DEF_WIDTH  = 12'd1280;
	localparam timing_t DEF_HFP    = 12'd110;
	localparam timing_t DEF_HS     = 12'd40;
	localparam timing_t DEF_HBP    = 12'd220;
	localparam timing_t DEF_HEIGHT = 12'd720;
	localparam timing_t DEF_VFP    = 12'd5;
	localparam timing_t DEF_VS     = 12'd5;
	localparam timing_t DEF_VBP    = 12'd20;

	// Phase counter of the sync polarity fix, enough for a full frame
	localparam int PHASE_CNT_W = 20;

endpackage

// ==== logic/hps_io_ctrl.sv ====
// Host word synchronizer, strobe and acknowledge handshake, command decoder, board LED mux

`timescale 1ns/1ps

module hps_io_ctrl (
	input  logic                FPGA_CLK2_50,
	input  logic                resetd,
	input  hps_pkg::host_word_t gp_out,
	output hps_pkg::host_word_t gp_in,
	input  logic                btn_user,
	input  logic                btn_osd,
	input  logic                led_user,
	input  logic [1:0]          led_power,
	input  logic [1:0]          led_disk,
	output logic [7:0]          led,
	output av_pkg::vol_t        vol,
	output av_pkg::timing_t     width,
	output av_pkg::timing_t     hfp,
	output av_pkg::timing_t     hs,
	output av_pkg::timing_t     hbp,
	output av_pkg::timing_t     height,
	output av_pkg::timing_t     vfp,
	output av_pkg::timing_t     vs,
	output av_pkg::timing_t     vbp
);
	import hps_pkg::*;
	import av_pkg::*;

	localparam int CNT_W = $clog2(TIMING_WORDS + 1);

	host_word_t       gp_outd;
	host_word_t       gp_outr;
	io_data_t         io_din;
	logic             io_clk;
	logic             io_uio;
	logic             io_ready;
	logic             rack;
	logic             io_ack;
	logic             io_strobe;
	logic             strobe_q;
	logic             has_cmd;
	cmd_t             cmd;
	logic [CNT_W-1:0] cnt;
	logic [7:0]       led_overtake;
	logic [7:0]       led_state;
	logic             led_p;
	logic             led_d;
	host_word_t       status;

	// ======================================================================
	// Host word synchronizer and handshake
	// ======================================================================

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			gp_outd <= '0;
			gp_outr <= '0;
		end else begin
			gp_outd <= gp_out;
			gp_outr <= gp_outd;
		end
	end

	assign io_din   = gp_outr[15:0];
	assign io_clk   = gp_outr[HOST_CLK_BIT];
	assign io_uio   = gp_outr[HOST_UIO_BIT];
	assign io_ready = gp_outr[HOST_READY_BIT];

	// Rising edge of the registered host clk
	assign io_strobe = io_clk & ~rack;

	// Ack trails the host clk by four edges, loads land on the same edge
	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			rack     <= 1'b0;
			io_ack   <= 1'b0;
			strobe_q <= 1'b0;
		end else begin
			rack     <= io_clk;
			io_ack   <= rack;
			strobe_q <= io_strobe;
		end
	end

	// ======================================================================
	// Command decoder
	// ======================================================================

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			has_cmd      <= 1'b0;
			cmd          <= '0;
			cnt          <= '0;
			width        <= DEF_WIDTH;
			hfp          <= DEF_HFP;
			hs           <= DEF_HS;
			hbp          <= DEF_HBP;
			height       <= DEF_HEIGHT;
			vfp          <= DEF_VFP;
			vs           <= DEF_VS;
			vbp          <= DEF_VBP;
			led_overtake <= '0;
			led_state    <= '0;
			vol          <= '0;
		end else if (!io_uio) begin
			has_cmd <= 1'b0;
		end else if (strobe_q) begin
			if (!has_cmd) begin
				// First word after uio rises is the command
				has_cmd <= 1'b1;
				cmd     <= io_din[7:0];
				cnt     <= '0;
			end else begin
				case (cmd)
					CMD_TIMING: begin
						// Extra words past the eighth are dropped
						if (cnt < CNT_W'(TIMING_WORDS)) begin
							cnt <= cnt + 1'b1;
							case (cnt)
								CNT_W'(0): width  <= io_din[11:0];
								CNT_W'(1): hfp    <= io_din[11:0];
								CNT_W'(2): hs     <= io_din[11:0];
								CNT_W'(3): hbp    <= io_din[11:0];
								CNT_W'(4): height <= io_din[11:0];
								CNT_W'(5): vfp    <= io_din[11:0];
								CNT_W'(6): vs     <= io_din[11:0];
								default:   vbp    <= io_din[11:0];
							endcase
						end
					end
					CMD_LED: begin
						led_overtake <= io_din[15:8];
						led_state    <= io_din[7:0];
					end
					CMD_VOLUME: vol <= io_din[4:0];
					default: ;
				endcase
			end
		end
	end

	// ======================================================================
	// Status word and board LEDs
	// ======================================================================

	always_comb begin
		status                     = '0;
		status[STAT_BTN_USER_BIT]  = btn_user;
		status[STAT_BTN_OSD_BIT]   = btn_osd;
		status[STAT_VER_LSB +: 2]  = IO_VER;
		status[STAT_ACK_BIT]       = io_ack;
	end

	// Magic until the host marks the link ready
	assign gp_in = io_ready ? status : CORE_MAGIC;

	// Power light only when the core claims it
	assign led_p = led_power[1] ? led_power[0] : 1'b0;
	// Disk light follows the core's disk bit in either mode
	assign led_d = led_disk[0];

	assign led = (led_overtake & led_state) |
		(~led_overtake & {3'b000, led_p, 1'b0, led_d, 1'b0, led_user});

	// Ack moves only two edges after the registered clk moved
	a_ack_after_clk: assert property (@(posedge FPGA_CLK2_50) disable iff (resetd)
		$changed(io_ack) |-> ($past(io_clk, 2) != $past(io_clk, 3)));

	a_timing_idx: assert property (@(posedge FPGA_CLK2_50) disable iff (resetd)
		(has_cmd && cmd == CMD_TIMING) |-> (cnt <= CNT_W'(TIMING_WORDS)));

endmodule

// ==== logic/audio_mixer.sv ====
// Two stage stereo cross-mix and volume attenuation pipeline

`timescale 1ns/1ps

module audio_mixer (
	input  logic            FPGA_CLK2_50,
	input  logic            resetd,
	input  av_pkg::sample_t audio_l_in,
	input  av_pkg::sample_t audio_r_in,
	input  logic            audio_signed,
	input  av_pkg::mix_t    audio_mix,
	input  av_pkg::vol_t    vol,
	output av_pkg::sample_t audio_l,
	output av_pkg::sample_t audio_r
);
	import av_pkg::*;

	sample_t mix_l;
	sample_t mix_r;
	logic    sgn_q;

	// Right shift, arithmetic for signed samples
	function automatic sample_t shr(input sample_t x, input logic [3:0] n, input logic sgn);
		if (sgn)
			return sample_t'($signed(x) >>> n);
		return x >> n;
	endfunction

	// One channel of the cross-mix, sums wrap at 16 bits
	function automatic sample_t cross_mix(
		input sample_t own,
		input sample_t other,
		input mix_t    mode,
		input logic    sgn
	);
		case (mode)
			2'd1:    return own - shr(own, 4'd3, sgn) + shr(other, 4'd3, sgn);
			2'd2:    return own - shr(own, 4'd2, sgn) + shr(other, 4'd2, sgn);
			2'd3:    return shr(own, 4'd1, sgn) + shr(other, 4'd1, sgn);
			default: return own;
		endcase
	endfunction

	// ======================================================================
	// Stage one, cross-mix
	// ======================================================================

	// Signedness travels with the pair into stage two
	always_ff @(posedge FPGA_CLK2_50) begin
		mix_l <= cross_mix(audio_l_in, audio_r_in, audio_mix, audio_signed);
		mix_r <= cross_mix(audio_r_in, audio_l_in, audio_mix, audio_signed);
		sgn_q <= audio_signed;
	end

	// ======================================================================
	// Stage two, volume
	// ======================================================================

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			audio_l <= '0;
			audio_r <= '0;
		end else if (vol[4]) begin
			audio_l <= '0;
			audio_r <= '0;
		end else begin
			audio_l <= shr(mix_l, vol[3:0], sgn_q);
			audio_r <= shr(mix_r, vol[3:0], sgn_q);
		end
	end

	a_mute: assert property (@(posedge FPGA_CLK2_50) disable iff (resetd)
		vol[4] |=> (audio_l == '0 && audio_r == '0));

endmodule

// ==== logic/button_debounce.sv ====
// Divided rate eight sample debouncer for the user and OSD buttons

`timescale 1ns/1ps

module button_debounce #(
	parameter int DEBOUNCE_DIV = 100000
) (
	input  logic FPGA_CLK2_50,
	input  logic resetd,
	input  logic btn_user_n,
	input  logic btn_osd_n,
	output logic btn_user,
	output logic btn_osd
);
	localparam int DIV_W = (DEBOUNCE_DIV > 1) ? $clog2(DEBOUNCE_DIV) : 1;

	logic [DIV_W-1:0] div;
	logic             tick;
	logic [1:0]       pressed;

	// One sample tick every DEBOUNCE_DIV clocks
	assign tick = (div == DIV_W'(DEBOUNCE_DIV - 1));

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd || tick)
			div <= '0;
		else
			div <= div + 1'b1;
	end

	// Buttons are active low
	assign pressed = {~btn_osd_n, ~btn_user_n};

	for (genvar i = 0; i < 2; i++) begin : g_btn
		logic [7:0] hist;
		logic [7:0] hist_nxt;
		logic       state;

		assign hist_nxt = {hist[6:0], pressed[i]};

		// Output flips only on a full run of eight equal samples
		always_ff @(posedge FPGA_CLK2_50) begin
			if (resetd) begin
				hist  <= '0;
				state <= 1'b0;
			end else if (tick) begin
				hist <= hist_nxt;
				if (&hist_nxt)
					state <= 1'b1;
				else if (hist_nxt == '0)
					state <= 1'b0;
			end
		end
	end

	assign btn_user = g_btn[0].state;
	assign btn_osd  = g_btn[1].state;

endmodule

// ==== logic/sync_polarity.sv ====
// Sync phase length measurement and polarity correction

`timescale 1ns/1ps

module sync_polarity (
	input  logic FPGA_CLK2_50,
	input  logic resetd,
	input  logic sync_in,
	output logic sync_out
);
	import av_pkg::*;

	logic                   s1;
	logic                   s2;
	logic [PHASE_CNT_W-1:0] cnt;
	logic [PHASE_CNT_W-1:0] lo_len;
	logic [PHASE_CNT_W-1:0] hi_len;
	logic                   pol;

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			s1     <= 1'b0;
			s2     <= 1'b0;
			cnt    <= '0;
			lo_len <= '0;
			hi_len <= '0;
			pol    <= 1'b0;
		end else begin
			s1 <= sync_in;
			s2 <= s1;

			// Length of the current level, held at full scale
			if (s1 != s2)
				cnt <= '0;
			else if (~&cnt)
				cnt <= cnt + 1'b1;

			// Rising edge closes a low phase, falling edge a high one
			if (s1 & ~s2)
				lo_len <= cnt;
			if (~s1 & s2)
				hi_len <= cnt;

			pol <= (hi_len > lo_len);
		end
	end

	// Short phase always ends up high
	assign sync_out = sync_in ^ pol;

endmodule

// ==== logic/sys_top.sv ====
// Board top with host link control, audio mixer, button debouncer and sync fixers

`timescale 1ns/1ps

module sys_top #(
	parameter int DEBOUNCE_DIV = 100000
) (
	input  logic                FPGA_CLK2_50,
	input  logic                resetd,
	input  hps_pkg::host_word_t gp_out,
	output hps_pkg::host_word_t gp_in,
	input  logic                btn_user_n,
	input  logic                btn_osd_n,
	input  logic                led_user,
	input  logic [1:0]          led_power,
	input  logic [1:0]          led_disk,
	output logic [7:0]          led,
	input  av_pkg::sample_t     audio_l_in,
	input  av_pkg::sample_t     audio_r_in,
	input  logic                audio_signed,
	input  av_pkg::mix_t        audio_mix,
	output av_pkg::sample_t     audio_l,
	output av_pkg::sample_t     audio_r,
	input  logic                vs_in,
	input  logic                hs_in,
	output logic                vs_out,
	output logic                hs_out,
	output av_pkg::timing_t     width,
	output av_pkg::timing_t     hfp,
	output av_pkg::timing_t     hs,
	output av_pkg::timing_t     hbp,
	output av_pkg::timing_t     height,
	output av_pkg::timing_t     vfp,
	output av_pkg::timing_t     vs,
	output av_pkg::timing_t     vbp
);
	import av_pkg::*;

	vol_t vol;
	logic btn_user;
	logic btn_osd;

	// ======================================================================
	// Host link and control registers
	// ======================================================================

	hps_io_ctrl u_hps_io_ctrl (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.gp_out       (gp_out),
		.gp_in        (gp_in),
		.btn_user     (btn_user),
		.btn_osd      (btn_osd),
		.led_user     (led_user),
		.led_power    (led_power),
		.led_disk     (led_disk),
		.led          (led),
		.vol          (vol),
		.width        (width),
		.hfp          (hfp),
		.hs           (hs),
		.hbp          (hbp),
		.height       (height),
		.vfp          (vfp),
		.vs           (vs),
		.vbp          (vbp)
	);

	// ======================================================================
	// Datapath
	// ======================================================================

	audio_mixer u_audio_mixer (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.audio_l_in   (audio_l_in),
		.audio_r_in   (audio_r_in),
		.audio_signed (audio_signed),
		.audio_mix    (audio_mix),
		.vol          (vol),
		.audio_l      (audio_l),
		.audio_r      (audio_r)
	);

	button_debounce #(
		.DEBOUNCE_DIV (DEBOUNCE_DIV)
	) u_button_debounce (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.btn_user_n   (btn_user_n),
		.btn_osd_n    (btn_osd_n),
		.btn_user     (btn_user),
		.btn_osd      (btn_osd)
	);

	// Core sync can arrive in either polarity
	sync_polarity sync_v (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.sync_in      (vs_in),
		.sync_out     (vs_out)
	);

	sync_polarity sync_h (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.sync_in      (hs_in),
		.sync_out     (hs_out)
	);

endmodule

// ==== tb/tb_sys_top.sv ====
// Directed testbench for sys_top with clock, reset, LFSR, reference models, tests and watchdog

`timescale 1ns/1ps

module tb_sys_top;
	import hps_pkg::*;
	import av_pkg::*;

	localparam int CLK_PERIOD   = 8;
	localparam int DEBOUNCE_DIV = 4;
	localparam int ACK_TIMEOUT  = 16;
	localparam int PAIRS        = 4;
	localparam int SYNC_LONG    = 20;
	localparam int SYNC_SHORT   = 4;
	localparam int BTN_BOUND    = 9 * DEBOUNCE_DIV + 4;

	// Worst case cycles per test for the watchdog
	localparam int WORD_CYC  = 2 * (ACK_TIMEOUT + 1) + 2;
	localparam int CMD_CYC   = 6;
	localparam int T_LINK    = 10 + WORD_CYC;
	localparam int T_TIMING  = 2 + 10 * WORD_CYC + CMD_CYC;
	localparam int T_AUDIO   = 4 * 2 * PAIRS * 4;
	localparam int T_VOLUME  = 17 * (2 * WORD_CYC + CMD_CYC + 4);
	localparam int T_LED     = 32 * 2 + 2 * (2 * WORD_CYC + CMD_CYC + 2)
		+ 2 * (2 * DEBOUNCE_DIV + 3 * BTN_BOUND + 6);
	localparam int T_SYNC    = 2 * 4 * (SYNC_LONG + SYNC_SHORT) * 2;
	localparam int WD_CYCLES = 4 + T_LINK + T_TIMING + T_AUDIO + T_VOLUME + T_LED + T_SYNC + 200;

	logic        FPGA_CLK2_50;
	logic        resetd;
	host_word_t  gp_out;
	host_word_t  gp_in;
	logic        btn_user_n;
	logic        btn_osd_n;
	logic        led_user;
	logic [1:0]  led_power;
	logic [1:0]  led_disk;
	logic [7:0]  led;
	sample_t     audio_l_in;
	sample_t     audio_r_in;
	logic        audio_signed;
	mix_t        audio_mix;
	sample_t     audio_l;
	sample_t     audio_r;
	logic        vs_in;
	logic        hs_in;
	logic        vs_out;
	logic        hs_out;
	timing_t     width;
	timing_t     hfp;
	timing_t     hs;
	timing_t     hbp;
	timing_t     height;
	timing_t     vfp;
	timing_t     vs;
	timing_t     vbp;
	logic [95:0] tim_flat;

	logic [31:0] lfsr_state;
	int          errors;
	int          tests_run;
	int          tests_failed;

	string       tim_names [8] = '{"width", "hfp", "hs", "hbp", "height", "vfp", "vs", "vbp"};
	logic [11:0] tim_defaults [8] = '{12'd1280, 12'd110, 12'd40, 12'd220,
		12'd720, 12'd5, 12'd5, 12'd20};

	assign tim_flat = {vbp, vs, vfp, height, hbp, hs, hfp, width};

	sys_top #(
		.DEBOUNCE_DIV (DEBOUNCE_DIV)
	) dut0 (
		.FPGA_CLK2_50 (FPGA_CLK2_50), .resetd (resetd),
		.gp_out (gp_out), .gp_in (gp_in),
		.btn_user_n (btn_user_n), .btn_osd_n (btn_osd_n),
		.led_user (led_user), .led_power (led_power), .led_disk (led_disk), .led (led),
		.audio_l_in (audio_l_in), .audio_r_in (audio_r_in),
		.audio_signed (audio_signed), .audio_mix (audio_mix),
		.audio_l (audio_l), .audio_r (audio_r),
		.vs_in (vs_in), .hs_in (hs_in), .vs_out (vs_out), .hs_out (hs_out),
		.width (width), .hfp (hfp), .hs (hs), .hbp (hbp),
		.height (height), .vfp (vfp), .vs (vs), .vbp (vbp)
	);

	initial begin
		FPGA_CLK2_50 = 1'b0;
		forever #(CLK_PERIOD / 2) FPGA_CLK2_50 = ~FPGA_CLK2_50;
	end

	// ======================================================================
	// Random source and reference models
	// ======================================================================

	// Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
	function automatic logic [15:0] rand_word(input int n);
		logic [15:0] r;
		logic        fb;
		r = '0;
		for (int k = 0; k < n; k++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			r = {r[14:0], fb};
		end
		return r;
	endfunction

	// Shifts one bit at a time and refills the sign bit for signed samples
	function automatic logic [15:0] shift_ref(input logic [15:0] x, input int n, input logic sgn);
		logic [15:0] r;
		r = x;
		for (int k = 0; k < n; k++)
			r = {sgn & r[15], r[15:1]};
		return r;
	endfunction

	function automatic logic [15:0] mix_ref(input logic [15:0] own, input logic [15:0] other,
		input logic [1:0] mode, input logic sgn);
		case (mode)
			2'd0: return own;
			2'd1: return own - shift_ref(own, 3, sgn) + shift_ref(other, 3, sgn);
			2'd2: return own - shift_ref(own, 2, sgn) + shift_ref(other, 2, sgn);
			default: return shift_ref(own, 1, sgn) + shift_ref(other, 1, sgn);
		endcase
	endfunction

	// ======================================================================
	// Host link helpers
	// ======================================================================

	task automatic wait_ack(input logic lvl);
		int n;
		n = 0;
		@(negedge FPGA_CLK2_50);
		while (gp_in[STAT_ACK_BIT] !== lvl && n < ACK_TIMEOUT) begin
			@(negedge FPGA_CLK2_50);
			n++;
		end
		assert (gp_in[STAT_ACK_BIT] === lvl) else begin
			$display("Acknowledge did not follow host clk to %0d within %0d cycles",
				lvl, ACK_TIMEOUT);
			errors++;
		end
	endtask

	// Word is taken on the rising host clk and clk then returns low
	task automatic send_word(input logic [15:0] data, input logic uio);
		host_word_t w;
		w = '0;
		w[HOST_READY_BIT] = 1'b1;
		w[HOST_UIO_BIT] = uio;
		w[15:0] = data;
		w[HOST_CLK_BIT] = 1'b1;
		@(posedge FPGA_CLK2_50);
		gp_out <= w;
		wait_ack(1'b1);
		w[HOST_CLK_BIT] = 1'b0;
		@(posedge FPGA_CLK2_50);
		gp_out <= w;
		wait_ack(1'b0);
	endtask

	task automatic end_cmd();
		@(posedge FPGA_CLK2_50);
		gp_out <= 32'h8000_0000;
		repeat (4) @(posedge FPGA_CLK2_50);
	endtask

	task automatic finish_test(input string name, input int err_before);
		tests_run++;
		if (errors == err_before) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: FAIL", name);
			tests_failed++;
		end
	endtask

	// ======================================================================
	// Tests
	// ======================================================================

	task automatic link_identity();
		int e;
		e = errors;
		@(posedge FPGA_CLK2_50);
		gp_out <= '0;
		repeat (3) @(negedge FPGA_CLK2_50);
		assert (gp_in == 32'h5CA6_23A4) else begin
			$display("[ERROR] gp_in: got %h expected %h", gp_in, 32'h5CA6_23A4);
			errors++;
		end
		@(posedge FPGA_CLK2_50);
		gp_out <= 32'h8000_0000;
		repeat (3) @(negedge FPGA_CLK2_50);
		assert (gp_in == 32'h0001_0000) else begin
			$display("[ERROR] gp_in: got %h expected %h", gp_in, 32'h0001_0000);
			errors++;
		end
		send_word(rand_word(16), 1'b0);
		finish_test("link identity", e);
	endtask

	task automatic check_timing(input logic [11:0] exp_t [8]);
		for (int i = 0; i < 8; i++) begin
			assert (tim_flat[i*12 +: 12] == exp_t[i]) else begin
				$display("[ERROR] %s: got %h expected %h", tim_names[i],
					tim_flat[i*12 +: 12], exp_t[i]);
				errors++;
			end
		end
	endtask

	task automatic timing_registers();
		int          e;
		logic [15:0] w;
		logic [11:0] exp_t [8];
		e = errors;
		check_timing(tim_defaults);
		send_word(16'(CMD_TIMING), 1'b1);
		for (int i = 0; i < 8; i++) begin
			w = rand_word(16);
			exp_t[i] = w[11:0];
			send_word(w, 1'b1);
		end
		check_timing(exp_t);
		// Ninth word must be ignored
		send_word(rand_word(16), 1'b1);
		end_cmd();
		check_timing(exp_t);
		finish_test("timing registers", e);
	endtask

	task automatic apply_pair(input logic [15:0] l, input logic [15:0] r, input logic sgn,
		input logic [1:0] mode, input logic [15:0] exp_l, input logic [15:0] exp_r);
		@(posedge FPGA_CLK2_50);
		audio_l_in   <= l;
		audio_r_in   <= r;
		audio_signed <= sgn;
		audio_mix    <= mode;
		// A second pair enters right behind the first
		@(posedge FPGA_CLK2_50);
		audio_l_in   <= ~l;
		audio_r_in   <= ~r;
		@(posedge FPGA_CLK2_50);
		@(negedge FPGA_CLK2_50);
		assert (audio_l == exp_l && audio_r == exp_r) else begin
			$display("[ERROR] audio_l/audio_r: got %h/%h expected %h/%h (mode %0d signed %0d)",
				audio_l, audio_r, exp_l, exp_r, mode, sgn);
			errors++;
		end
	endtask

	task automatic audio_mixing();
		int          e;
		logic [15:0] l;
		logic [15:0] r;
		e = errors;
		for (int m = 0; m < 4; m++) begin
			for (int s = 0; s < 2; s++) begin
				for (int p = 0; p < PAIRS; p++) begin
					l = rand_word(16);
					r = rand_word(16);
					apply_pair(l, r, 1'(s), 2'(m), mix_ref(l, r, 2'(m), 1'(s)),
						mix_ref(r, l, 2'(m), 1'(s)));
				end
			end
		end
		finish_test("audio mixing", e);
	endtask

	task automatic volume_steps();
		int          e;
		logic [15:0] l;
		logic [15:0] r;
		logic [1:0]  m;
		logic        s;
		e = errors;
		for (int n = 0; n < 17; n++) begin
			send_word(16'(CMD_VOLUME), 1'b1);
			// Last pass sets mute with a random shift
			send_word((n == 16) ? (16'h0010 | rand_word(4)) : 16'(n), 1'b1);
			end_cmd();
			l = rand_word(16);
			r = rand_word(16);
			m = 2'(rand_word(2));
			s = 1'(rand_word(1));
			if (n == 16)
				apply_pair(l, r, s, m, 16'h0000, 16'h0000);
			else
				apply_pair(l, r, s, m, shift_ref(mix_ref(l, r, m, s), n, s),
					shift_ref(mix_ref(r, l, m, s), n, s));
		end
		finish_test("volume", e);
	endtask

	task automatic check_led(input logic [7:0] ot, input logic [7:0] st);
		logic [7:0] dflt;
		logic [7:0] exp_led;
		dflt = '0;
		dflt[0] = led_user;
		dflt[2] = led_disk[0];
		dflt[4] = led_power[1] & led_power[0];
		for (int b = 0; b < 8; b++)
			exp_led[b] = ot[b] ? st[b] : dflt[b];
		assert (led == exp_led) else begin
			$display("[ERROR] led: got %h expected %h", led, exp_led);
			errors++;
		end
	endtask

	task automatic set_btn(input int pos, input logic lvl_n);
		@(posedge FPGA_CLK2_50);
		if (pos == STAT_BTN_USER_BIT)
			btn_user_n <= lvl_n;
		else
			btn_osd_n <= lvl_n;
	endtask

	task automatic button_press(input int pos);
		logic bad;
		logic seen;
		bad = 1'b0;
		// Short glitch must never reach the status word
		set_btn(pos, 1'b0);
		repeat (2 * DEBOUNCE_DIV - 1) begin
			@(negedge FPGA_CLK2_50);
			bad |= gp_in[pos];
		end
		set_btn(pos, 1'b1);
		repeat (BTN_BOUND) begin
			@(negedge FPGA_CLK2_50);
			bad |= gp_in[pos];
		end
		assert (!bad) else begin
			$display("[ERROR] gp_in[%0d]: got %h expected %h", pos, 1'b1, 1'b0);
			errors++;
		end
		for (int lvl = 0; lvl < 2; lvl++) begin
			set_btn(pos, 1'(lvl));
			seen = 1'b0;
			for (int c = 0; c < BTN_BOUND && !seen; c++) begin
				@(negedge FPGA_CLK2_50);
				seen = (gp_in[pos] == 1'(1 - lvl));
			end
			assert (seen) else begin
				$display("Button at status bit %0d did not settle to %0d within %0d cycles",
					pos, 1 - lvl, BTN_BOUND);
				errors++;
			end
		end
	endtask

	task automatic leds_and_buttons();
		int          e;
		logic [15:0] w;
		e = errors;
		for (int i = 0; i < 32; i++) begin
			@(posedge FPGA_CLK2_50);
			{led_power, led_disk, led_user} <= 5'(i);
			@(negedge FPGA_CLK2_50);
			check_led(8'h00, 8'h00);
		end
		for (int k = 0; k < 2; k++) begin
			w = rand_word(16);
			send_word(16'(CMD_LED), 1'b1);
			send_word(w, 1'b1);
			end_cmd();
			check_led(w[15:8], w[7:0]);
		end
		button_press(STAT_BTN_USER_BIT);
		button_press(STAT_BTN_OSD_BIT);
		finish_test("leds and buttons", e);
	endtask

	task automatic drive_sync(input logic lvl, input int n, input logic chk, input logic exp_out);
		repeat (n) begin
			@(posedge FPGA_CLK2_50);
			hs_in <= lvl;
			vs_in <= lvl;
			@(negedge FPGA_CLK2_50);
			if (chk) begin
				assert (hs_out == exp_out && vs_out == exp_out) else begin
					$display("[ERROR] hs_out/vs_out: got %h/%h expected %h",
						hs_out, vs_out, exp_out);
					errors++;
				end
			end
		end
	endtask

	task automatic sync_correction();
		int e;
		int hi;
		int lo;
		e = errors;
		for (int long_high = 1; long_high >= 0; long_high--) begin
			hi = long_high ? SYNC_LONG : SYNC_SHORT;
			lo = long_high ? SYNC_SHORT : SYNC_LONG;
			// Two periods to settle and two checked ones
			for (int p = 0; p < 4; p++) begin
				drive_sync(1'b1, hi, p >= 2, 1'(!long_high));
				drive_sync(1'b0, lo, p >= 2, 1'(long_high));
			end
		end
		finish_test("sync polarity", e);
	endtask

	// ======================================================================
	// Main sequence and watchdog
	// ======================================================================

	initial begin
		lfsr_state   = 32'hd6fb_e44e;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		resetd       = 1'b1;
		gp_out       = '0;
		btn_user_n   = 1'b1;
		btn_osd_n    = 1'b1;
		led_user     = 1'b0;
		led_power    = 2'b00;
		led_disk     = 2'b00;
		audio_l_in   = '0;
		audio_r_in   = '0;
		audio_signed = 1'b0;
		audio_mix    = '0;
		vs_in        = 1'b0;
		hs_in        = 1'b0;
		repeat (4) @(posedge FPGA_CLK2_50);
		resetd <= 1'b0;

		link_identity();
		timing_registers();
		audio_mixing();
		volume_steps();
		leds_and_buttons();
		sync_correction();

		$display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	initial begin
		#(WD_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the run did not finish", WD_CYCLES);
		$display("Some tests failed");
		$finish;
	end

endmodule

// ==== filelist.f ====
logic/hps_pkg.sv
logic/av_pkg.sv
logic/hps_io_ctrl.sv
logic/audio_mixer.sv
logic/button_debounce.sv
logic/sync_polarity.sv
logic/sys_top.sv
tb/tb_sys_top.sv
